/* src/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data path and address width
`define CPU_WORD_W 16

// Register file size
`define CPU_NUM_REGS 8

// Register index width, bits 7..5 and 10..8 of the instruction
`define CPU_REG_ADDR_W 3

// Opcode field, bits 4..0
`define CPU_OPCODE_W 5

// First fetch address
`define CPU_RESET_PC 16'h0000

`endif

/* src/cpu_pkg.sv */
`include "cpu_defines.svh"

package cpu_pkg;

  typedef logic [`CPU_WORD_W-1:0]     word_t;
  typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

  typedef enum logic [`CPU_OPCODE_W-1:0] {
    MV    = 5'd0,
    ADD   = 5'd1,
    SUB   = 5'd2,
    CMP   = 5'd3,
    LD    = 5'd4,
    ST    = 5'd5,
    MVI   = 5'd6,
    ADDI  = 5'd7,
    SUBI  = 5'd8,
    CMPI  = 5'd9,
    MVHI  = 5'd10,
    JR    = 5'd11,
    JZR   = 5'd12,
    JNR   = 5'd13,
    CALLR = 5'd14,
    J     = 5'd15,
    JZ    = 5'd16,
    JN    = 5'd17,
    HALT  = 5'd31
  } opcode_e;

  typedef enum logic [1:0] {
    FETCH,
    DECODE,
    MEM_WAIT,
    HALTED
  } ctrl_state_e;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  write;
  } mem_req_t;

  // Register write data source
  typedef enum logic [2:0] {IMM8, HIBYTE, ALU, LINK, MEMDATA, RY} rf_src_e;

  typedef enum logic [1:0] {REG, SEQ, REL} pc_src_e;

  typedef enum logic {PC, RX} addr_src_e;

endpackage

/* src/cpu_regfile.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_regfile import cpu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_reset,
  input  logic      i_write,
  input  reg_addr_t i_waddr,
  input  word_t     i_wdata,
  input  reg_addr_t i_raddr_x,
  input  reg_addr_t i_raddr_y,
  output word_t     o_rdata_x,
  output word_t     o_rdata_y
);

  word_t regs [`CPU_NUM_REGS];

  always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_write) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // No bypass, a read in the write cycle sees the old value
  assign o_rdata_x = regs[i_raddr_x];
  assign o_rdata_y = regs[i_raddr_y];

endmodule

/* src/cpu_alu.sv */
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
  input  logic  i_sub,
  input  word_t i_op_a,
  input  word_t i_op_b,
  output word_t o_result,
  output logic  o_n,
  output logic  o_z
);

  word_t result;

  // Wraps at 16 bits, no carry out
  always_comb begin
    if (i_sub) begin
      result = i_op_a - i_op_b;
    end else begin
      result = i_op_a + i_op_b;
    end
  end

  assign o_result = result;
  assign o_n      = result[$bits(word_t)-1];
  assign o_z      = (result == '0);

endmodule

/* src/cpu_datapath.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_datapath import cpu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_reset,

  // Selects from control
  input  logic      i_ir_ld,
  input  logic      i_pc_ld,
  input  pc_src_e   i_pc_src,
  input  logic      i_rf_write,
  input  logic      i_rf_waddr_sel,
  input  rf_src_e   i_rf_src,
  input  logic      i_alu_sub,
  input  logic      i_alu_b_imm,
  input  logic      i_n_ld,
  input  logic      i_z_ld,
  input  addr_src_e i_addr_src,

  input  word_t     i_mem_rdata,

  output opcode_e   o_opcode,
  output logic      o_n,
  output logic      o_z,
  output word_t     o_mem_addr,
  output word_t     o_mem_wdata
);

  word_t     pc;
  word_t     pc_seq;
  word_t     pc_rel;
  word_t     pc_next;
  word_t     ir;
  word_t     imm8;
  word_t     imm11;

  reg_addr_t rx;
  reg_addr_t ry;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;
  word_t     rdata_x;
  word_t     rdata_y;

  word_t     alu_b;
  word_t     alu_result;
  logic      alu_n;
  logic      alu_z;

  cpu_regfile u_regfile (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_write   (i_rf_write),
    .i_waddr   (rf_waddr),
    .i_wdata   (rf_wdata),
    .i_raddr_x (rx),
    .i_raddr_y (ry),
    .o_rdata_x (rdata_x),
    .o_rdata_y (rdata_y)
  );

  cpu_alu u_alu (
    .i_sub    (i_alu_sub),
    .i_op_a   (rdata_x),
    .i_op_b   (alu_b),
    .o_result (alu_result),
    .o_n      (alu_n),
    .o_z      (alu_z)
  );

  always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
      pc  <= `CPU_RESET_PC;
      ir  <= '0;
      o_n <= 1'b0;
      o_z <= 1'b0;
    end else begin
      if (i_pc_ld) pc <= pc_next;
      if (i_ir_ld) ir <= i_mem_rdata;
      if (i_n_ld)  o_n <= alu_n;
      if (i_z_ld)  o_z <= alu_z;
    end
  end

  // Instruction fields
  assign o_opcode = opcode_e'(ir[`CPU_OPCODE_W-1:0]);
  assign rx       = ir[7:5];
  assign ry       = ir[10:8];
  assign imm8     = {{8{ir[15]}}, ir[15:8]};
  assign imm11    = {{5{ir[15]}}, ir[15:5]};

  // Offsets count words, so shift by one for the byte address
  assign pc_seq = pc + 16'd2;
  assign pc_rel = pc_seq + {imm11[14:0], 1'b0};

  assign alu_b    = i_alu_b_imm ? imm8 : rdata_y;
  assign rf_waddr = i_rf_waddr_sel ? ry : rx;

  always_comb begin
    case (i_rf_src)
      IMM8:    rf_wdata = imm8;
      HIBYTE:  rf_wdata = {imm8[7:0], rdata_x[7:0]};
      ALU:     rf_wdata = alu_result;
      LINK:    rf_wdata = pc_seq;
      MEMDATA: rf_wdata = i_mem_rdata;
      RY:      rf_wdata = rdata_y;
      default: rf_wdata = '0;
    endcase

    case (i_pc_src)
      REG:     pc_next = rdata_x;
      SEQ:     pc_next = pc_seq;
      REL:     pc_next = pc_rel;
      default: pc_next = pc_seq;
    endcase
  end

  assign o_mem_addr  = (i_addr_src == RX) ? rdata_x : pc;
  assign o_mem_wdata = rdata_y;

endmodule

/* src/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control import cpu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_reset,
  input  opcode_e   i_opcode,
  input  logic      i_n,
  input  logic      i_z,
  input  logic      i_mem_req_ready,
  input  logic      i_mem_rsp_valid,

  output logic      o_ir_ld,
  output logic      o_pc_ld,
  output pc_src_e   o_pc_src,
  output logic      o_rf_write,
  output logic      o_rf_waddr_sel,
  output rf_src_e   o_rf_src,
  output logic      o_alu_sub,
  output logic      o_alu_b_imm,
  output logic      o_n_ld,
  output logic      o_z_ld,
  output addr_src_e o_addr_src,

  output logic      o_mem_req_valid,
  output logic      o_mem_write,
  output logic      o_halted
);

  ctrl_state_e state;
  ctrl_state_e state_nxt;

  // Low until the first edge after reset release
  logic run;
  // Fetch accepted, response not yet seen
  logic fetch_wait;
  logic fetch_req;

  assign fetch_req = (state == FETCH) && run && !fetch_wait;
  assign o_halted  = (state == HALTED);

  always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
      state      <= FETCH;
      run        <= 1'b0;
      fetch_wait <= 1'b0;
    end else begin
      state <= state_nxt;
      run   <= 1'b1;
      if (fetch_req && i_mem_req_ready) begin
        fetch_wait <= 1'b1;
      end else if (fetch_wait && i_mem_rsp_valid) begin
        fetch_wait <= 1'b0;
      end
    end
  end

  always_comb begin
    state_nxt       = state;
    o_ir_ld         = 1'b0;
    o_pc_ld         = 1'b0;
    o_pc_src        = SEQ;
    o_rf_write      = 1'b0;
    o_rf_waddr_sel  = 1'b0;
    o_rf_src        = ALU;
    o_alu_sub       = 1'b0;
    o_alu_b_imm     = 1'b0;
    o_n_ld          = 1'b0;
    o_z_ld          = 1'b0;
    o_addr_src      = PC;
    o_mem_req_valid = 1'b0;
    o_mem_write     = 1'b0;

    case (state)
      FETCH: begin
        o_mem_req_valid = fetch_req;
        if (fetch_wait && i_mem_rsp_valid) begin
          o_ir_ld   = 1'b1;
          state_nxt = DECODE;
        end
      end

      DECODE: begin
        o_addr_src = RX;
        o_pc_ld    = 1'b1;
        state_nxt  = FETCH;
        case (i_opcode)
          MV: begin
            o_rf_write = 1'b1;
            o_rf_src   = RY;
          end
          ADD, SUB, CMP, ADDI, SUBI, CMPI: begin
            o_rf_write  = !(i_opcode inside {CMP, CMPI});
            o_alu_sub   = i_opcode inside {SUB, CMP, SUBI, CMPI};
            o_alu_b_imm = i_opcode inside {ADDI, SUBI, CMPI};
            o_n_ld      = 1'b1;
            o_z_ld      = 1'b1;
          end
          MVI: begin
            o_rf_write = 1'b1;
            o_rf_src   = IMM8;
          end
          MVHI: begin
            o_rf_write = 1'b1;
            o_rf_src   = HIBYTE;
          end
          LD, ST: begin
            // PC advances only once the request is taken
            o_mem_req_valid = 1'b1;
            o_mem_write     = (i_opcode == ST);
            o_pc_ld         = i_mem_req_ready;
            if (!i_mem_req_ready) begin
              state_nxt = DECODE;
            end else if (i_opcode == LD) begin
              state_nxt = MEM_WAIT;
            end
          end
          JR:  o_pc_src = REG;
          JZR: o_pc_src = i_z ? REG : SEQ;
          JNR: o_pc_src = i_n ? REG : SEQ;
          CALLR: begin
            o_rf_write     = 1'b1;
            o_rf_waddr_sel = 1'b1;
            o_rf_src       = LINK;
            o_pc_src       = REG;
          end
          J:  o_pc_src = REL;
          JZ: o_pc_src = i_z ? REL : SEQ;
          JN: o_pc_src = i_n ? REL : SEQ;
          // HALT and any undefined opcode
          default: begin
            o_pc_ld   = 1'b0;
            state_nxt = HALTED;
          end
        endcase
      end

      MEM_WAIT: begin
        o_rf_waddr_sel = 1'b1;
        o_rf_src       = MEMDATA;
        if (i_mem_rsp_valid) begin
          o_rf_write = 1'b1;
          state_nxt  = FETCH;
        end
      end

      default: state_nxt = HALTED;
    endcase
  end

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
  input  logic     i_clk,
  input  logic     i_reset,
  input  logic     i_mem_req_ready,
  input  logic     i_mem_rsp_valid,
  input  word_t    i_mem_rdata,
  output logic     o_mem_req_valid,
  output mem_req_t o_mem_req,
  output logic     o_halted
);

  opcode_e   opcode;
  logic      flag_n;
  logic      flag_z;
  logic      ir_ld;
  logic      pc_ld;
  pc_src_e   pc_src;
  logic      rf_write;
  logic      rf_waddr_sel;
  rf_src_e   rf_src;
  logic      alu_sub;
  logic      alu_b_imm;
  logic      n_ld;
  logic      z_ld;
  addr_src_e addr_src;
  logic      mem_write;
  word_t     mem_addr;
  word_t     mem_wdata;

  cpu_control u_control (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_opcode        (opcode),
    .i_n             (flag_n),
    .i_z             (flag_z),
    .i_mem_req_ready (i_mem_req_ready),
    .i_mem_rsp_valid (i_mem_rsp_valid),
    .o_ir_ld         (ir_ld),
    .o_pc_ld         (pc_ld),
    .o_pc_src        (pc_src),
    .o_rf_write      (rf_write),
    .o_rf_waddr_sel  (rf_waddr_sel),
    .o_rf_src        (rf_src),
    .o_alu_sub       (alu_sub),
    .o_alu_b_imm     (alu_b_imm),
    .o_n_ld          (n_ld),
    .o_z_ld          (z_ld),
    .o_addr_src      (addr_src),
    .o_mem_req_valid (o_mem_req_valid),
    .o_mem_write     (mem_write),
    .o_halted        (o_halted)
  );

  cpu_datapath u_datapath (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_ir_ld        (ir_ld),
    .i_pc_ld        (pc_ld),
    .i_pc_src       (pc_src),
    .i_rf_write     (rf_write),
    .i_rf_waddr_sel (rf_waddr_sel),
    .i_rf_src       (rf_src),
    .i_alu_sub      (alu_sub),
    .i_alu_b_imm    (alu_b_imm),
    .i_n_ld         (n_ld),
    .i_z_ld         (z_ld),
    .i_addr_src     (addr_src),
    .i_mem_rdata    (i_mem_rdata),
    .o_opcode       (opcode),
    .o_n            (flag_n),
    .o_z            (flag_z),
    .o_mem_addr     (mem_addr),
    .o_mem_wdata    (mem_wdata)
  );

  assign o_mem_req = '{addr: mem_addr, wdata: mem_wdata, write: mem_write};

endmodule

/* verif/cpu_asserts.sv */
`timescale 1ns/1ps

module cpu_asserts import cpu_pkg::*; (
  input logic     i_clk,
  input logic     i_reset,
  input logic     i_mem_req_ready,
  input logic     i_mem_rsp_valid,
  input logic     i_mem_req_valid,
  input mem_req_t i_mem_req,
  input logic     i_halted
);

  // Read accepted, response not yet returned
  logic rd_outstanding;

  // Failed assertion count
  int   fail_count = 0;

  always_ff @(posedge i_clk or negedge i_reset) begin
    if (!i_reset) begin
      rd_outstanding <= 1'b0;
    end else if (i_mem_req_valid && i_mem_req_ready && !i_mem_req.write) begin
      rd_outstanding <= 1'b1;
    end else if (i_mem_rsp_valid) begin
      rd_outstanding <= 1'b0;
    end
  end

  a_reset_quiet: assert property (@(posedge i_clk)
    !i_reset |-> !i_mem_req_valid && !i_halted)
    else begin
      $error("request or halt raised while reset is low");
      fail_count++;
    end

  a_req_stable: assert property (@(posedge i_clk) disable iff (!i_reset)
    i_mem_req_valid && !i_mem_req_ready |=> i_mem_req_valid && $stable(i_mem_req))
    else begin
      $error("request dropped or changed before acceptance");
      fail_count++;
    end

  a_halt_quiet: assert property (@(posedge i_clk) disable iff (!i_reset)
    i_halted |-> !i_mem_req_valid)
    else begin
      $error("request raised after halt");
      fail_count++;
    end

  // Memory model side
  a_rsp_expected: assert property (@(posedge i_clk) disable iff (!i_reset)
    i_mem_rsp_valid |-> rd_outstanding)
    else begin
      $error("read response without an outstanding read");
      fail_count++;
    end

endmodule

bind cpu_top cpu_asserts u_asserts (
  .i_clk           (i_clk),
  .i_reset         (i_reset),
  .i_mem_req_ready (i_mem_req_ready),
  .i_mem_rsp_valid (i_mem_rsp_valid),
  .i_mem_req_valid (o_mem_req_valid),
  .i_mem_req       (o_mem_req),
  .i_halted        (o_halted)
);

/* verif/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

  localparam int    CLK_PERIOD   = 8;
  localparam int    NUM_TESTS    = 6;
  localparam int    CYCLE_BUDGET = 2000;
  localparam int    RAND_N       = 1024;
  localparam int    LOOPS        = 5;
  localparam word_t DATA_BASE    = 16'hFF80;
  localparam word_t DATA_SRC     = 16'hFFA0;

  logic     clk;
  logic     reset_n;
  logic     mem_req_ready;
  logic     mem_rsp_valid;
  word_t    mem_rdata;
  logic     mem_req_valid;
  mem_req_t mem_req;
  logic     halted;

  word_t       mem [256];
  mem_req_t    wr_log [$];
  mem_req_t    exp_q [$];
  int unsigned ready_dly [RAND_N];
  int unsigned lat_dly [RAND_N];
  int          rand_idx;
  int          prog_ptr;
  int          checks;
  int          errors;

  // Memory model state
  int          ready_cnt;
  int          lat_cnt;
  logic        rd_pending;
  word_t       rd_addr;

  cpu_top u_dut (
    .i_clk           (clk),
    .i_reset         (reset_n),
    .i_mem_req_ready (mem_req_ready),
    .i_mem_rsp_valid (mem_rsp_valid),
    .i_mem_rdata     (mem_rdata),
    .o_mem_req_valid (mem_req_valid),
    .o_mem_req       (mem_req),
    .o_halted        (halted)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic int mem_index(word_t addr);
    return int'(addr[8:1]);
  endfunction

  // Ready after 0..3 idle cycles, read data 1..4 cycles after acceptance
  always @(posedge clk) begin
    mem_rsp_valid <= 1'b0;
    if (!reset_n) begin
      mem_req_ready <= 1'b0;
      rd_pending = 1'b0;
      ready_cnt  = 0;
      lat_cnt    = 0;
    end else begin
      if (rd_pending) begin
        if (lat_cnt == 0) begin
          mem_rsp_valid <= 1'b1;
          mem_rdata     <= mem[mem_index(rd_addr)];
          rd_pending = 1'b0;
        end else begin
          lat_cnt--;
        end
      end
      if (mem_req_valid && mem_req_ready) begin
        mem_req_ready <= 1'b0;
        ready_cnt = ready_dly[rand_idx];
        lat_cnt   = lat_dly[rand_idx];
        rand_idx  = (rand_idx + 1) % RAND_N;
        if (mem_req.write) begin
          mem[mem_index(mem_req.addr)] = mem_req.wdata;
          wr_log.push_back(mem_req);
        end else begin
          rd_pending = 1'b1;
          rd_addr    = mem_req.addr;
        end
      end else if (mem_req_valid) begin
        if (ready_cnt == 0) begin
          mem_req_ready <= 1'b1;
        end else begin
          ready_cnt--;
        end
      end
    end
  end

  function automatic word_t reg_instr(opcode_e op, int rx, int ry);
    return {5'b0, ry[2:0], rx[2:0], op};
  endfunction

  function automatic word_t imm_instr(opcode_e op, int rx, int imm);
    return {imm[7:0], rx[2:0], op};
  endfunction

  function automatic word_t jump_instr(opcode_e op, int off);
    return {off[10:0], op};
  endfunction

  task automatic emit(word_t instr);
    mem[prog_ptr] = instr;
    prog_ptr++;
  endtask

  task automatic store_next(int r);
    emit(reg_instr(ST, 7, r));
    emit(imm_instr(ADDI, 7, 2));
  endtask

  task automatic expect_write(word_t addr, word_t data);
    mem_req_t req;
    req = '{addr: addr, wdata: data, write: 1'b1};
    exp_q.push_back(req);
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_req(string name, mem_req_t exp, mem_req_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s: expected addr %h data %h write %b, actual addr %h data %h write %b",
               name, exp.addr, exp.wdata, exp.write, act.addr, act.wdata, act.write);
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic start_test();
    @(posedge clk);
    reset_n <= 1'b0;
    // HALT opcode in the low byte, word index in the high byte
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0], 8'h1F};
    end
    wr_log.delete();
    exp_q.delete();
    prog_ptr = 0;
  endtask

  task automatic wait_for_halt(string name);
    int cycles;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;
    cycles = 0;
    while (!halted && cycles < CYCLE_BUDGET) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      errors++;
      $display("%s: the core did not halt within %0d cycles", name, CYCLE_BUDGET);
    end
  endtask

  task automatic finish_test(string name);
    wait_for_halt(name);
    check_count({name, " write count"}, exp_q.size(), wr_log.size());
    for (int i = 0; i < exp_q.size() && i < wr_log.size(); i++) begin
      check_req($sformatf("%s write %0d", name, i), exp_q[i], wr_log[i]);
    end
  endtask

  task automatic immediate_moves();
    start_test();
    emit(imm_instr(MVI, 7, 8'h80));
    emit(imm_instr(MVI, 1, 8'h35));
    emit(imm_instr(MVI, 2, 8'hF0));
    emit(imm_instr(MVI, 3, 8'h12));
    emit(imm_instr(MVHI, 3, 8'hAB));
    emit(reg_instr(MV, 4, 3));
    emit(imm_instr(MVI, 5, 8'h80));
    emit(imm_instr(MVHI, 5, 8'h12));
    for (int r = 1; r <= 5; r++) begin
      store_next(r);
    end
    emit(reg_instr(HALT, 0, 0));
    expect_write(DATA_BASE, 16'h0035);
    expect_write(DATA_BASE + 2, 16'hFFF0);
    expect_write(DATA_BASE + 4, 16'hAB12);
    expect_write(DATA_BASE + 6, 16'hAB12);
    expect_write(DATA_BASE + 8, 16'h1280);
    finish_test("moves");
  endtask

  task automatic arithmetic();
    start_test();
    emit(imm_instr(MVI, 7, 8'h80));
    emit(imm_instr(MVI, 1, 8'hFF));
    emit(imm_instr(MVHI, 1, 8'h7F));
    emit(imm_instr(MVI, 2, 1));
    emit(reg_instr(ADD, 1, 2));
    emit(imm_instr(MVI, 3, 0));
    emit(imm_instr(SUBI, 3, 1));
    emit(imm_instr(MVI, 4, 100));
    emit(imm_instr(ADDI, 4, -25));
    emit(imm_instr(MVI, 5, 16));
    emit(reg_instr(SUB, 5, 4));
    emit(imm_instr(MVI, 6, 8'h80));
    emit(reg_instr(ADD, 6, 6));
    store_next(1);
    store_next(3);
    store_next(4);
    store_next(5);
    store_next(6);
    emit(reg_instr(HALT, 0, 0));
    expect_write(DATA_BASE, word_t'(16'h7FFF + 16'h0001));
    expect_write(DATA_BASE + 2, word_t'(16'h0000 - 16'h0001));
    expect_write(DATA_BASE + 4, word_t'(16'd100 - 16'd25));
    expect_write(DATA_BASE + 6, word_t'(16'd16 - 16'd75));
    expect_write(DATA_BASE + 8, word_t'(16'hFF80 + 16'hFF80));
    finish_test("arith");
  endtask

  // Taken path stores 0x11 from r5, fall-through stores 0x22 from r6
  task automatic branch_case(word_t cmp_instr, word_t a, word_t b, opcode_e op);
    word_t diff;
    logic  taken;
    int    taken_addr;
    diff       = a - b;
    taken      = (op inside {JZ, JZR}) ? (diff == '0) : diff[15];
    taken_addr = 2 * prog_ptr + 10;
    emit(imm_instr(MVI, 4, taken_addr));
    emit(cmp_instr);
    if (op inside {JZR, JNR}) begin
      emit(reg_instr(op, 4, 0));
    end else begin
      emit(jump_instr(op, 2));
    end
    emit(reg_instr(ST, 7, 6));
    emit(jump_instr(J, 1));
    emit(reg_instr(ST, 7, 5));
    expect_write(DATA_BASE, taken ? 16'h0011 : 16'h0022);
  endtask

  task automatic flag_branches();
    start_test();
    emit(imm_instr(MVI, 7, 8'h80));
    emit(imm_instr(MVI, 5, 8'h11));
    emit(imm_instr(MVI, 6, 8'h22));
    emit(imm_instr(MVI, 1, 5));
    emit(imm_instr(MVI, 2, 9));
    branch_case(imm_instr(CMPI, 1, 5), 16'd5, 16'd5, JZ);
    branch_case(imm_instr(CMPI, 1, 6), 16'd5, 16'd6, JZ);
    branch_case(imm_instr(CMPI, 1, 6), 16'd5, 16'd6, JN);
    branch_case(imm_instr(CMPI, 1, 4), 16'd5, 16'd4, JN);
    branch_case(reg_instr(CMP, 1, 1), 16'd5, 16'd5, JZR);
    branch_case(reg_instr(CMP, 1, 2), 16'd5, 16'd9, JZR);
    branch_case(reg_instr(CMP, 1, 2), 16'd5, 16'd9, JNR);
    branch_case(imm_instr(CMPI, 1, 5), 16'd5, 16'd5, JNR);
    emit(reg_instr(HALT, 0, 0));
    finish_test("branches");
  endtask

  task automatic load_store();
    word_t data [5];
    start_test();
    for (int k = 0; k < 5; k++) begin
      data[k] = word_t'($urandom);
      mem[mem_index(DATA_SRC + 2 * k)] = data[k];
    end
    emit(imm_instr(MVI, 1, 8'hA0));
    emit(imm_instr(MVI, 7, 8'h80));
    emit(imm_instr(MVI, 3, 6));
    for (int k = 0; k < 5; k++) begin
      emit(reg_instr(LD, 1, 2));
      emit(imm_instr(ADDI, 1, 2));
      emit(reg_instr(ST, 7, 2));
      emit(reg_instr(ADD, 7, 3));
      expect_write(DATA_BASE + 6 * k, data[k]);
    end
    emit(reg_instr(HALT, 0, 0));
    finish_test("load_store");
    for (int k = 0; k < 5; k++) begin
      check_word($sformatf("load_store mem %0d", k), data[k],
                 mem[mem_index(DATA_BASE + 6 * k)]);
    end
  endtask

  task automatic jumps_and_call();
    int call_addr;
    start_test();
    emit(imm_instr(MVI, 7, 8'h80));
    emit(imm_instr(MVI, 1, 0));
    emit(imm_instr(MVI, 2, LOOPS));
    emit(jump_instr(J, 1));
    emit(reg_instr(HALT, 0, 0));
    // Loop body at byte 10
    emit(imm_instr(ADDI, 1, 1));
    emit(imm_instr(SUBI, 2, 1));
    emit(jump_instr(JZ, 1));
    emit(jump_instr(J, -4));
    store_next(1);
    emit(imm_instr(MVI, 3, 32));
    call_addr = 2 * prog_ptr;
    emit(reg_instr(CALLR, 3, 4));
    emit(imm_instr(MVI, 6, 8'h77));
    emit(reg_instr(ST, 7, 6));
    emit(reg_instr(HALT, 0, 0));
    // Subroutine at byte 32 stores its link and returns
    emit(reg_instr(ST, 7, 4));
    emit(imm_instr(ADDI, 7, 2));
    emit(reg_instr(JR, 4, 0));
    expect_write(DATA_BASE, LOOPS);
    expect_write(DATA_BASE + 2, call_addr + 2);
    expect_write(DATA_BASE + 4, 16'h0077);
    finish_test("jumps");
  endtask

  task automatic halt_hold();
    int held;
    int reqs;
    start_test();
    emit(imm_instr(MVI, 7, 8'h80));
    emit(imm_instr(MVI, 1, 8'h5A));
    emit(reg_instr(ST, 7, 1));
    emit(reg_instr(HALT, 0, 0));
    emit(reg_instr(ST, 7, 1));
    emit(reg_instr(HALT, 0, 0));
    expect_write(DATA_BASE, 16'h005A);
    finish_test("halt");
    held = 0;
    reqs = 0;
    repeat (50) begin
      @(negedge clk);
      if (halted) held++;
      if (mem_req_valid) reqs++;
    end
    check_count("halt cycles held", 50, held);
    check_count("halt requests", 0, reqs);
    check_count("halt writes", 1, wr_log.size());
  endtask

  initial begin
    clk           = 1'b0;
    reset_n       = 1'b0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rdata     = '0;
    rand_idx      = 0;
    checks        = 0;
    errors        = 0;
    void'($urandom(33));
    for (int i = 0; i < RAND_N; i++) begin
      ready_dly[i] = $urandom_range(3, 0);
      lat_dly[i]   = $urandom_range(3, 0);
    end
    immediate_moves();
    arithmetic();
    flag_branches();
    load_store();
    jumps_and_call();
    halt_hold();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, u_dut.u_asserts.fail_count);
    if (errors == 0 && u_dut.u_asserts.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Budget covers every test plus one spare for reset overhead
  initial begin
    #((NUM_TESTS + 1) * CYCLE_BUDGET * CLK_PERIOD);
    $display("Watchdog expired, the simulation hung");
    $display("Test failures found");
    $finish;
  end

endmodule

/* tb.f */
+incdir+src
src/cpu_pkg.sv
src/cpu_regfile.sv
src/cpu_alu.sv
src/cpu_datapath.sv
src/cpu_control.sv
src/cpu_top.sv
verif/cpu_asserts.sv
verif/cpu_tb.sv
